// File: lz_trace.txt
// per stream: byte count, token count, then the bytes, then the tokens
// token word is {is_lit, last, payload}, payload {len, dst} for pairs
// distinct bytes, literals only
0008 0008
41 42 43 44 45 46 47 48
241 242 243 244 245 246 247 348
// repeated abc, literal prefix then pairs at distance 3
0009 0005
61 62 63 61 62 63 61 62 63
261 262 263 033 133
// run of 39 equal bytes, pairs capped at length 15
0027 0007
61 61 61 61 61 61 61 61 61 61 61 61 61
61 61 61 61 61 61 61 61 61 61 61 61 61
61 61 61 61 61 61 61 61 61 61 61 61 61
261 261 261 033 066 0cc 1ff
// two bytes
0002 0002
61 61
261 361
// same byte again, earlier streams stay out of the window
0006 0004
61 61 61 61 61 61
261 261 261 133
// end of trace
0000

// File: lz77_top.f
+incdir+.
lz_pkg.sv
lz_fetch.sv
lz_window.sv
lz_match.sv
lz_ctrl.sv
lz77_top.sv
lz_checker.sv
tb_lz77.sv

// File: Makefile
# Verilator build for the LZ77 compressor testbench

SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_lz77
FILELIST = lz77_top.f
OBJDIR   = obj_dir
PASS_MSG = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: tb_lz77.sv
`include "lz_config.svh"

module tb_lz77
  import lz_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF    = 2;
  localparam int RST_CYCLES  = 16;
  localparam int TRACE_MAX   = 256;
  // cycles allowed per stream byte before a stream counts as stuck
  localparam int BYTE_BUDGET = `LZ_AHD_DEPTH + 8;

  logic      clk;
  logic      rstn;
  logic      start;
  lz_cnt_t   cfg_len;
  logic      rd;
  lz_byte_t  src_dat = '0;
  logic      tok_val;
  lz_token_t tok;
  logic      done;

  // expected tokens towards the checker
  logic      exp_push = 1'b0;
  lz_token_t exp_tok  = '0;
  int        strm_done;
  int        tok_cnt;
  int        err_cnt;

  logic [15:0] trace_mem [0:TRACE_MAX-1];
  int          strm_cnt  = 0;
  int          src_base  = 0;
  int          src_len   = 0;
  int          src_pos   = 0;
  int          src_strm  = 0;
  int          src_err   = 0;
  logic        rd_seen   = 1'b0;
  logic        timed_out;
  logic        trace_bad;

  lz77_top u_lz77_top (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start),
    .cfg_len_i (cfg_len),
    .rd_o      (rd),
    .src_dat_i (src_dat),
    .tok_val_o (tok_val),
    .tok_o     (tok),
    .done_o    (done)
  );

  lz_checker u_lz_checker (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start),
    .cfg_len_i   (cfg_len),
    .rd_i        (rd),
    .tok_val_i   (tok_val),
    .tok_i       (tok),
    .done_i      (done),
    .exp_push_i  (exp_push),
    .exp_tok_i   (exp_tok),
    .strm_done_o (strm_done),
    .tok_cnt_o   (tok_cnt),
    .err_cnt_o   (err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  // ---------------------------------------------------------------------
  // byte source, next stream byte one cycle after each read
  // ---------------------------------------------------------------------
  always @(negedge clk) begin
    if (src_strm != strm_cnt) begin
      src_strm = strm_cnt;
      src_pos  = 0;
    end
    if (rd_seen) begin
      if (src_pos >= src_len) begin
        $display("source read past the end of stream %0d at %0t", strm_cnt, $time);
        src_err = src_err + 1;
      end else begin
        src_dat = lz_byte_t'(trace_mem[src_base + src_pos]);
        src_pos = src_pos + 1;
      end
    end
    rd_seen = rd;
  end

  // ---------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------
  task automatic push_expected(input lz_token_t t);
    @(posedge clk);
    exp_tok  <= t;
    exp_push <= 1'b1;
    @(posedge clk);
    exp_push <= 1'b0;
  endtask

  task automatic pulse_start(input lz_cnt_t n);
    @(negedge clk);
    cfg_len = n;
    start   = 1'b1;
    @(negedge clk);
    start   = 1'b0;
  endtask

  task automatic wait_stream_done(input int target, input int limit);
    int cyc;
    cyc = 0;
    while (strm_done < target && cyc < limit) begin
      @(negedge clk);
      cyc++;
    end
    if (strm_done < target) begin
      $display("timeout waiting for done on stream %0d after %0d cycles", target, cyc);
      timed_out = 1'b1;
    end
  endtask

  // record layout: byte count, token count, bytes, tokens
  task automatic run_stream(input int base, output int next);
    int len;
    int ntok;
    len      = int'(trace_mem[base]);
    ntok     = int'(trace_mem[base+1]);
    strm_cnt = strm_cnt + 1;
    src_base = base + 2;
    src_len  = len;
    for (int i = 0; i < ntok; i++) begin
      push_expected(lz_token_t'(trace_mem[base + 2 + len + i]));
    end
    pulse_start(lz_cnt_t'(len));
    wait_stream_done(strm_cnt, len * BYTE_BUDGET + 4 * `LZ_AHD_DEPTH);
    next = base + 2 + len + ntok;
  endtask

  initial begin
    int idx;
    int nxt;
    rstn      = 1'b0;
    start     = 1'b0;
    cfg_len   = '0;
    timed_out = 1'b0;
    trace_bad = 1'b0;
    idx       = 0;
    nxt       = 0;
    $readmemh("lz_trace.txt", trace_mem);
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    // streams until the zero length word
    while (!timed_out && !trace_bad && idx < TRACE_MAX - 2 && trace_mem[idx] != 16'h0000) begin
      if (idx + 2 + int'(trace_mem[idx]) + int'(trace_mem[idx+1]) >= TRACE_MAX) begin
        $display("trace record at word %0d runs past the end of the trace", idx);
        trace_bad = 1'b1;
      end else begin
        run_stream(idx, nxt);
        idx = nxt;
      end
    end

    // room for stray tokens after the last stream
    repeat (8) @(negedge clk);
    $display("summary: %0d of %0d streams done, %0d tokens, %0d errors",
             strm_done, strm_cnt, tok_cnt, err_cnt + src_err);
    if (!timed_out && !trace_bad && strm_cnt > 0 && strm_done == strm_cnt &&
        err_cnt == 0 && src_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: lz_checker.sv
module lz_checker
  import lz_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      start_i,
  input  lz_cnt_t   cfg_len_i,
  input  logic      rd_i,
  input  logic      tok_val_i,
  input  lz_token_t tok_i,
  input  logic      done_i,
  input  logic      exp_push_i,
  input  lz_token_t exp_tok_i,
  output int        strm_done_o,
  output int        tok_cnt_o,
  output int        err_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  lz_token_t exp_q [$];
  int        started   = 0;
  lz_cnt_t   cur_len   = '0;
  int        strm_done = 0;
  int        tok_cnt   = 0;
  int        err_cnt   = 0;
  int        rd_cnt    = 0;
  int        strm_tok  = 0;
  int        strm_err  = 0;
  logic      open;

  // a stream is open from its start until its done pulse
  assign open = (started > strm_done);

  task automatic log_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    err_cnt  = err_cnt + 1;
    strm_err = strm_err + 1;
  endtask

  // ---------------------------------------------------------------------
  // stream opening, taken where the DUT samples it
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    if (rstn && start_i) begin
      started <= started + 1;
      cur_len <= cfg_len_i;
    end
  end

  // ---------------------------------------------------------------------
  // DUT outputs, compared mid-cycle
  // ---------------------------------------------------------------------
  always @(negedge clk) begin
    lz_token_t want;
    if (rstn) begin
      if (exp_push_i) begin
        exp_q.push_back(exp_tok_i);
      end
      if (rd_i) begin
        if (!open) begin
          log_error("read strobe outside a stream");
        end
        rd_cnt = rd_cnt + 1;
      end
      if (tok_val_i) begin
        tok_cnt  = tok_cnt + 1;
        strm_tok = strm_tok + 1;
        if (!open) begin
          log_error($sformatf("token %03h before start", tok_i));
        end else if (exp_q.size() == 0) begin
          log_error($sformatf("unexpected token %03h", tok_i));
        end else begin
          want = exp_q.pop_front();
          if (tok_i !== want) begin
            log_error($sformatf("stream %0d token %0d expected %03h got %03h",
                                strm_done + 1, strm_tok, want, tok_i));
          end
        end
      end
      // done and the last flag belong to the same cycle
      if (tok_val_i && tok_i.last && !done_i) begin
        log_error("last token without done");
      end
      if (done_i && !(tok_val_i && tok_i.last)) begin
        log_error("done without a last token");
      end
      if (done_i) begin
        if (!open) begin
          log_error("done outside a stream");
        end else begin
          if (exp_q.size() != 0) begin
            log_error($sformatf("stream %0d ended with %0d tokens missing",
                                strm_done + 1, exp_q.size()));
          end
          if (rd_cnt != int'(cur_len)) begin
            log_error($sformatf("stream %0d expected %0d reads got %0d",
                                strm_done + 1, cur_len, rd_cnt));
          end
          $display("stream %0d: %0d tokens, %0d reads, %s", strm_done + 1, strm_tok,
                   rd_cnt, (strm_err == 0) ? "passed" : "failed");
          strm_done <= strm_done + 1;
        end
        rd_cnt   = 0;
        strm_tok = 0;
        strm_err = 0;
      end
    end
  end

  assign strm_done_o = strm_done;
  assign tok_cnt_o   = tok_cnt;
  assign err_cnt_o   = err_cnt;

endmodule

// File: lz77_top.sv
module lz77_top
  import lz_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  // stream control
  input  logic      start_i,
  input  lz_cnt_t   cfg_len_i,
  // byte source
  output logic      rd_o,
  input  lz_byte_t  src_dat_i,
  // token output
  output logic      tok_val_o,
  output lz_token_t tok_o,
  output logic      done_o
);

  logic      fill_req;
  lz_len_t   fill_cnt;
  logic      fill_done;
  logic      shf_val;
  lz_shf_t   shf;
  lz_store_t store;
  logic      srch_go;
  logic      res_val;
  lz_res_t   res;

  // ---------------------------------------------------------------------
  // fetch, window, match, control
  // ---------------------------------------------------------------------
  lz_fetch u_lz_fetch (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .cfg_len_i   (cfg_len_i),
    .fill_req_i  (fill_req),
    .fill_cnt_i  (fill_cnt),
    .rd_o        (rd_o),
    .src_dat_i   (src_dat_i),
    .shf_val_o   (shf_val),
    .shf_o       (shf),
    .fill_done_o (fill_done)
  );

  lz_window u_lz_window (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .shf_val_i (shf_val),
    .shf_i     (shf),
    .store_o   (store)
  );

  lz_match u_lz_match (
    .clk       (clk),
    .rstn      (rstn),
    .srch_go_i (srch_go),
    .store_i   (store),
    .res_val_o (res_val),
    .res_o     (res)
  );

  lz_ctrl u_lz_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .cfg_len_i   (cfg_len_i),
    .fill_done_i (fill_done),
    .fill_req_o  (fill_req),
    .fill_cnt_o  (fill_cnt),
    .srch_go_o   (srch_go),
    .res_val_i   (res_val),
    .res_i       (res),
    .tok_val_o   (tok_val_o),
    .tok_o       (tok_o),
    .done_o      (done_o)
  );

endmodule

// File: lz_ctrl.sv
`include "lz_config.svh"

module lz_ctrl
  import lz_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      start_i,
  input  lz_cnt_t   cfg_len_i,
  input  logic      fill_done_i,
  output logic      fill_req_o,
  output lz_len_t   fill_cnt_o,
  output logic      srch_go_o,
  input  logic      res_val_i,
  input  lz_res_t   res_i,
  output logic      tok_val_o,
  output lz_token_t tok_o,
  output logic      done_o
);

  // one-hot states
  localparam logic [2:0] IDLE = 3'b001;
  localparam logic [2:0] FILL = 3'b010;
  localparam logic [2:0] SRCH = 3'b100;

  logic [2:0] state_r;
  lz_cnt_t    cfg_r;
  lz_cnt_t    emit_cnt_r;
  logic       fill_req_r;
  lz_len_t    fill_cnt_r;
  logic       srch_go_r;
  logic       tok_val_r;
  logic       done_r;
  lz_token_t  tok_r;

  lz_cnt_t    emit_nx;
  logic       last;
  lz_token_t  tok_nx;

  // ---------------------------------------------------------------------
  // token build
  // ---------------------------------------------------------------------
  assign emit_nx = emit_cnt_r + lz_cnt_t'(res_i.len);
  assign last    = (emit_nx == cfg_r);

  always_comb begin
    tok_nx.is_lit = res_i.is_lit;
    tok_nx.last   = last;
    if (res_i.is_lit) begin
      tok_nx.pld.lit = res_i.lit_dat;
    end else begin
      tok_nx.pld.pair.len = res_i.len;
      tok_nx.pld.pair.dst = res_i.dst;
    end
  end

  // ---------------------------------------------------------------------
  // idle, fill and search loop
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r    <= IDLE;
      cfg_r      <= '0;
      emit_cnt_r <= '0;
      fill_req_r <= 1'b0;
      fill_cnt_r <= '0;
      srch_go_r  <= 1'b0;
      tok_val_r  <= 1'b0;
      done_r     <= 1'b0;
    end else begin
      fill_req_r <= 1'b0;
      srch_go_r  <= 1'b0;
      tok_val_r  <= 1'b0;
      done_r     <= 1'b0;
      case (state_r)
        IDLE: begin
          if (start_i) begin
            cfg_r      <= cfg_len_i;
            emit_cnt_r <= '0;
            // prime the whole lookahead
            fill_req_r <= 1'b1;
            fill_cnt_r <= lz_len_t'(`LZ_AHD_DEPTH);
            state_r    <= FILL;
          end
        end
        FILL: begin
          if (fill_done_i) begin
            srch_go_r <= 1'b1;
            state_r   <= SRCH;
          end
        end
        SRCH: begin
          if (res_val_i) begin
            tok_val_r  <= 1'b1;
            emit_cnt_r <= emit_nx;
            if (last) begin
              done_r  <= 1'b1;
              state_r <= IDLE;
            end else begin
              // slide by the bytes just coded
              fill_req_r <= 1'b1;
              fill_cnt_r <= res_i.len;
              state_r    <= FILL;
            end
          end
        end
        default: begin
          state_r <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (res_val_i) begin
      tok_r <= tok_nx;
    end
  end

  assign fill_req_o = fill_req_r;
  assign fill_cnt_o = fill_cnt_r;
  assign srch_go_o  = srch_go_r;
  assign tok_val_o  = tok_val_r;
  assign tok_o      = tok_r;
  assign done_o     = done_r;

endmodule

// File: lz_match.sv
`include "lz_config.svh"

module lz_match
  import lz_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      srch_go_i,
  input  lz_store_t store_i,
  output logic      res_val_o,
  output lz_res_t   res_o
);

  localparam int WIN = `LZ_WIN_DEPTH;
  localparam int AHD = `LZ_AHD_DEPTH;

  // search state, bit d-1 of the vector stands for distance d
  logic           busy_r;
  lz_len_t        step_r;
  logic [WIN-1:0] mvec_r;
  lz_len_t        best_len_r;
  lz_dst_t        best_dst_r;
  lz_res_t        res_r;
  logic           res_val_r;

  logic           active;
  lz_len_t        step_cur;
  logic [WIN-1:0] mvec_cur;
  logic [WIN-1:0] mvec_nx;
  logic           next_vld;
  logic           hit;
  logic           stop;
  lz_len_t        best_len_nx;
  lz_dst_t        best_dst_nx;
  lz_res_t        res_nx;

  // lowest set bit wins, so ties go to the nearest copy
  function automatic lz_dst_t prio_dst(input logic [WIN-1:0] vec);
    lz_dst_t dst;
    dst = '0;
    for (int i = WIN - 1; i >= 0; i--) begin
      if (vec[i]) begin
        dst = lz_dst_t'(i + 1);
      end
    end
    return dst;
  endfunction

  // ---------------------------------------------------------------------
  // one lookahead byte per cycle, first compare in the go cycle
  // ---------------------------------------------------------------------
  assign active   = srch_go_i || busy_r;
  assign step_cur = srch_go_i ? '0 : step_r;
  assign mvec_cur = srch_go_i ? '1 : mvec_r;

  always_comb begin
    int ahd;
    int src;
    ahd = WIN + int'(step_cur);
    for (int d = 1; d <= WIN; d++) begin
      src = ahd - d;
      // a copy may not run past its own distance
      mvec_nx[d-1] = mvec_cur[d-1] && store_i.vld[ahd] && (int'(step_cur) < d) &&
                     store_i.vld[src] && (store_i.dat[src] == store_i.dat[ahd]);
    end
    next_vld = (int'(step_cur) < AHD - 1) ? store_i.vld[ahd+1] : 1'b0;
  end

  assign hit  = |mvec_nx;
  assign stop = !hit || !next_vld;

  assign best_len_nx = hit ? step_cur + 1'b1 : (srch_go_i ? '0 : best_len_r);
  assign best_dst_nx = hit ? prio_dst(mvec_nx) : (srch_go_i ? '0 : best_dst_r);

  // short copies fall back to a literal of the next byte
  always_comb begin
    res_nx.is_lit  = (best_len_nx < `LZ_LEN_MIN);
    res_nx.len     = res_nx.is_lit ? lz_len_t'(1) : best_len_nx;
    res_nx.dst     = res_nx.is_lit ? '0 : best_dst_nx;
    res_nx.lit_dat = store_i.dat[WIN];
  end

  // ---------------------------------------------------------------------
  // registers
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_r    <= 1'b0;
      step_r    <= '0;
      mvec_r    <= '0;
      res_val_r <= 1'b0;
    end else begin
      res_val_r <= active && stop;
      if (active) begin
        busy_r <= !stop;
        step_r <= step_cur + 1'b1;
        mvec_r <= mvec_nx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      best_len_r <= best_len_nx;
      best_dst_r <= best_dst_nx;
    end
    if (active && stop) begin
      res_r <= res_nx;
    end
  end

  assign res_val_o = res_val_r;
  assign res_o     = res_r;

endmodule

// File: lz_window.sv
module lz_window
  import lz_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      start_i,
  input  logic      shf_val_i,
  input  lz_shf_t   shf_i,
  output lz_store_t store_o
);

  // layout, oldest first
  //   slot 0           oldest window byte, distance WIN
  //   slot WIN-1       newest window byte, distance 1
  //   slot WIN         first lookahead byte
  //   slot ALL-1       newest fetched byte
  lz_byte_t [LZ_ALL_DEPTH-1:0] dat_r;
  logic     [LZ_ALL_DEPTH-1:0] vld_r;

  // ---------------------------------------------------------------------
  // valid bits
  // ---------------------------------------------------------------------

  // cleared at start so a new stream never sees old history
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_r <= '0;
    end else if (start_i) begin
      vld_r <= '0;
    end else if (shf_val_i) begin
      vld_r <= {shf_i.vld, vld_r[LZ_ALL_DEPTH-1:1]};
    end
  end

  // ---------------------------------------------------------------------
  // byte store
  // ---------------------------------------------------------------------

  // new byte enters at the top, slot 0 falls out
  always_ff @(posedge clk) begin
    if (shf_val_i) begin
      dat_r <= {shf_i.dat, dat_r[LZ_ALL_DEPTH-1:1]};
    end
  end

  // whole store goes to the search as a level
  always_comb begin
    store_o.dat = dat_r;
    store_o.vld = vld_r;
  end

endmodule

// File: lz_fetch.sv
module lz_fetch
  import lz_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     start_i,
  input  lz_cnt_t  cfg_len_i,
  input  logic     fill_req_i,
  input  lz_len_t  fill_cnt_i,
  output logic     rd_o,
  input  lz_byte_t src_dat_i,
  output logic     shf_val_o,
  output lz_shf_t  shf_o,
  output logic     fill_done_o
);

  // bytes of the stream not yet read
  lz_cnt_t rem_r;
  // shifts left in the running fill
  lz_len_t step_r;
  logic    issue;

  // one cycle behind issue, lines up with src_dat_i
  logic    pend_r;
  logic    pend_rd_r;
  logic    pend_last_r;

  // ---------------------------------------------------------------------
  // issue one shift per cycle, real read only while bytes remain
  // ---------------------------------------------------------------------
  assign issue = (step_r != '0);
  assign rd_o  = issue && (rem_r != '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rem_r       <= '0;
      step_r      <= '0;
      pend_r      <= 1'b0;
      pend_rd_r   <= 1'b0;
      pend_last_r <= 1'b0;
    end else begin
      if (start_i) begin
        rem_r <= cfg_len_i;
      end else if (rd_o) begin
        rem_r <= rem_r - 1'b1;
      end
      if (fill_req_i) begin
        step_r <= fill_cnt_i;
      end else if (issue) begin
        step_r <= step_r - 1'b1;
      end
      pend_r      <= issue;
      pend_rd_r   <= rd_o;
      pend_last_r <= issue && (step_r == lz_len_t'(1));
    end
  end

  // ---------------------------------------------------------------------
  // shift out, padding past the end of the stream
  // ---------------------------------------------------------------------
  always_comb begin
    shf_o.vld = pend_rd_r;
    shf_o.dat = pend_rd_r ? src_dat_i : '0;
  end

  assign shf_val_o   = pend_r;
  assign fill_done_o = pend_r && pend_last_r;

endmodule

// File: lz_pkg.sv
`include "lz_config.svh"

package lz_pkg;

  // derived sizes
  localparam int LZ_ALL_DEPTH = `LZ_WIN_DEPTH + `LZ_AHD_DEPTH;
  localparam int LZ_LEN_W     = $clog2(`LZ_AHD_DEPTH + 1);
  localparam int LZ_DST_W     = $clog2(`LZ_WIN_DEPTH + 1);

  typedef logic [`LZ_BYTE_W-1:0] lz_byte_t;
  typedef logic [LZ_LEN_W-1:0]   lz_len_t;
  typedef logic [LZ_DST_W-1:0]   lz_dst_t;
  typedef logic [`LZ_CNT_W-1:0]  lz_cnt_t;

  // one byte entering the store, vld low for padding
  typedef struct packed {
    logic     vld;
    lz_byte_t dat;
  } lz_shf_t;

  // slot 0 is the oldest window byte, slot WIN is the next byte to code
  typedef struct packed {
    lz_byte_t [LZ_ALL_DEPTH-1:0] dat;
    logic     [LZ_ALL_DEPTH-1:0] vld;
  } lz_store_t;

  typedef struct packed {
    logic     is_lit;
    lz_len_t  len;
    lz_dst_t  dst;
    lz_byte_t lit_dat;
  } lz_res_t;

  typedef struct packed {
    lz_len_t len;
    lz_dst_t dst;
  } lz_pair_t;

  // token word, meaning selected by the literal flag
  typedef union packed {
    lz_byte_t lit;
    lz_pair_t pair;
  } lz_payload_u;

  typedef struct packed {
    logic        is_lit;
    logic        last;
    lz_payload_u pld;
  } lz_token_t;

endpackage

// File: lz_config.svh
`ifndef LZ_CONFIG_SVH
`define LZ_CONFIG_SVH

// ---------------------------------------------------------------------
// compressor geometry
// ---------------------------------------------------------------------

// width of one stream byte
`define LZ_BYTE_W     8

// bytes of already coded history, distance fits in 4 bits
`define LZ_WIN_DEPTH  15

// bytes ahead of the coding position, also the longest match
`define LZ_AHD_DEPTH  15

// shortest copy worth a pair, anything below goes out as literal
`define LZ_LEN_MIN    3

// ---------------------------------------------------------------------
// stream control
// ---------------------------------------------------------------------

// width of the stream length given at start
`define LZ_CNT_W      16

`endif
